/* rtl/rvf_pkg.sv */
`default_nettype none

package rvf_pkg;

    // Addresses, instructions and data words all share one width.
    typedef logic [31:0] word_t;

    localparam word_t reset_pc = 32'h8000_0000; // First fetch after reset.
    localparam word_t pc_step  = 32'd4;         // One 32-bit instruction.

    // APB sequencing in the shared bus arbiter.
    typedef enum logic [1:0] {
        arb_idle   = 2'd0,
        arb_setup  = 2'd1,
        arb_access = 2'd2
    } arb_state_e;

    // Requester that currently holds the bus.
    typedef enum logic {
        owner_fetch = 1'b0,
        owner_data  = 1'b1
    } req_owner_e;

endpackage

`default_nettype wire

/* rtl/pc_gen.sv */
`default_nettype none

module pc_gen (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           hold,
    input  wire logic           redirect_valid,
    input  wire rvf_pkg::word_t redirect_pc,
    input  wire logic           fetch_done,
    input  wire logic           fetch_busy,
    output rvf_pkg::word_t      pc,
    output logic                fetch_en
);

    rvf_pkg::word_t redirect_target;
    logic           redirect_pending;
    logic           step_pending;     // Fetch finished while hold was high.
    logic           load_redirect;

    // The target is loaded only once the fetch in flight has returned.
    assign load_redirect = redirect_pending & ~fetch_busy;

    assign fetch_en = ~hold & ~redirect_pending & ~step_pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_pending <= 1'b0;
        end else if (redirect_valid) begin
            redirect_pending <= 1'b1; // Latest redirect wins.
        end else if (load_redirect) begin
            redirect_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect_valid) begin
            redirect_target <= redirect_pc;
        end
    end

    // A pending redirect outranks the step; a completion under hold
    // is remembered and applied when hold drops.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= rvf_pkg::reset_pc;
            step_pending <= 1'b0;
        end else if (load_redirect) begin
            pc           <= redirect_target;
            step_pending <= 1'b0;
        end else if (!redirect_pending) begin
            if (hold) begin
                if (fetch_done) begin
                    step_pending <= 1'b1;
                end
            end else if (fetch_done || step_pending) begin
                pc           <= pc + rvf_pkg::pc_step;
                step_pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/instr_fetch.sv */
`default_nettype none

module instr_fetch (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire rvf_pkg::word_t pc,
    input  wire logic           fetch_en,
    output logic                fetch_done,
    output logic                fetch_busy,
    output logic                req,
    output rvf_pkg::word_t      addr,
    input  wire logic           done,
    input  wire rvf_pkg::word_t rdata,
    output logic                instr_valid,
    output rvf_pkg::word_t      instr,
    output rvf_pkg::word_t      instr_pc
);

    logic busy;
    logic start;

    assign start = fetch_en & ~busy;

    // Request stays up for the whole transfer.
    assign req        = busy;
    assign fetch_busy = busy;
    assign fetch_done = done & busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (done) begin
                busy <= 1'b0;
            end
        end else if (fetch_en) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr <= pc; // Held stable until done.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= fetch_done;
        end
    end

    // Tag the returned word with the address it came from.
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr    <= rdata;
            instr_pc <= addr;
        end
    end

endmodule

`default_nettype wire

/* rtl/data_port.sv */
`default_nettype none

module data_port (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           dmem_req,
    input  wire logic           dmem_we,
    input  wire rvf_pkg::word_t dmem_addr,
    input  wire rvf_pkg::word_t dmem_wdata,
    output logic                dmem_done,
    output rvf_pkg::word_t      dmem_rdata,
    output logic                req,
    output logic                we,
    output rvf_pkg::word_t      addr,
    output rvf_pkg::word_t      wdata,
    input  wire logic           done,
    input  wire rvf_pkg::word_t rdata
);

    logic busy;
    logic accept;

    // Core pulses during a transfer are dropped.
    assign accept = dmem_req & ~busy;
    assign req    = busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (busy) begin
            if (done) begin
                busy <= 1'b0;
            end
        end else if (dmem_req) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr  <= dmem_addr;
            wdata <= dmem_wdata;
            we    <= dmem_we;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_done <= 1'b0;
        end else begin
            dmem_done <= done & busy;
        end
    end

    always_ff @(posedge clk) begin
        if (done && busy) begin
            dmem_rdata <= rdata; // Load data, don't care on stores.
        end
    end

endmodule

`default_nettype wire

/* rtl/bus_arbiter.sv */
`default_nettype none

module bus_arbiter (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           if_req,
    input  wire rvf_pkg::word_t if_addr,
    output logic                if_done,
    input  wire logic           dp_req,
    input  wire logic           dp_we,
    input  wire rvf_pkg::word_t dp_addr,
    input  wire rvf_pkg::word_t dp_wdata,
    output logic                dp_done,
    output rvf_pkg::word_t      rdata,
    output rvf_pkg::word_t      paddr,
    output rvf_pkg::word_t      pwdata,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    input  wire rvf_pkg::word_t prdata,
    input  wire logic           pready
);

    rvf_pkg::arb_state_e state;
    rvf_pkg::req_owner_e owner;

    logic want_data;
    logic want_fetch;
    logic complete;

    // A requester still sees its own done high for one cycle
    // and must not be granted again on it.
    assign want_data  = dp_req & ~dp_done;
    assign want_fetch = if_req & ~if_done;

    assign complete = (state == rvf_pkg::arb_access) & pready;

    assign psel    = (state != rvf_pkg::arb_idle);
    assign penable = (state == rvf_pkg::arb_access);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rvf_pkg::arb_idle;
            owner <= rvf_pkg::owner_fetch;
        end else begin
            case (state)
                rvf_pkg::arb_idle: begin
                    if (want_data) begin
                        owner <= rvf_pkg::owner_data; // Data port has priority.
                        state <= rvf_pkg::arb_setup;
                    end else if (want_fetch) begin
                        owner <= rvf_pkg::owner_fetch;
                        state <= rvf_pkg::arb_setup;
                    end
                end
                rvf_pkg::arb_setup: begin
                    state <= rvf_pkg::arb_access;
                end
                rvf_pkg::arb_access: begin
                    if (pready) begin
                        state <= rvf_pkg::arb_idle;
                    end
                end
                default: begin
                    state <= rvf_pkg::arb_idle;
                end
            endcase
        end
    end

    // Address phase fields, captured at grant and held through access.
    always_ff @(posedge clk) begin
        if (state == rvf_pkg::arb_idle) begin
            if (want_data) begin
                paddr  <= dp_addr;
                pwdata <= dp_wdata;
                pwrite <= dp_we;
            end else if (want_fetch) begin
                paddr  <= if_addr;
                pwdata <= '0;
                pwrite <= 1'b0; // Fetches are reads.
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_done <= 1'b0;
            dp_done <= 1'b0;
        end else begin
            if_done <= complete & (owner == rvf_pkg::owner_fetch);
            dp_done <= complete & (owner == rvf_pkg::owner_data);
        end
    end

    always_ff @(posedge clk) begin
        if (complete) begin
            rdata <= prdata;
        end
    end

endmodule

`default_nettype wire

/* rtl/fetch_subsystem.sv */
`default_nettype none

module fetch_subsystem (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           hold,
    input  wire logic           redirect_valid,
    input  wire rvf_pkg::word_t redirect_pc,
    output logic                instr_valid,
    output rvf_pkg::word_t      instr,
    output rvf_pkg::word_t      instr_pc,
    input  wire logic           dmem_req,
    input  wire logic           dmem_we,
    input  wire rvf_pkg::word_t dmem_addr,
    input  wire rvf_pkg::word_t dmem_wdata,
    output logic                dmem_done,
    output rvf_pkg::word_t      dmem_rdata,
    output rvf_pkg::word_t      paddr,
    output rvf_pkg::word_t      pwdata,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    input  wire rvf_pkg::word_t prdata,
    input  wire logic           pready
);

    rvf_pkg::word_t pc;
    logic           fetch_en;
    logic           fetch_done;
    logic           fetch_busy;

    logic           if_req;
    rvf_pkg::word_t if_addr;
    logic           if_done;

    logic           dp_req;
    logic           dp_we;
    rvf_pkg::word_t dp_addr;
    rvf_pkg::word_t dp_wdata;
    logic           dp_done;

    rvf_pkg::word_t bus_rdata; // Shared by both requesters.

    pc_gen i_pc_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .hold           (hold),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .fetch_done     (fetch_done),
        .fetch_busy     (fetch_busy),
        .pc             (pc),
        .fetch_en       (fetch_en)
    );

    instr_fetch i_instr_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (pc),
        .fetch_en    (fetch_en),
        .fetch_done  (fetch_done),
        .fetch_busy  (fetch_busy),
        .req         (if_req),
        .addr        (if_addr),
        .done        (if_done),
        .rdata       (bus_rdata),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc)
    );

    data_port i_data_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_done  (dmem_done),
        .dmem_rdata (dmem_rdata),
        .req        (dp_req),
        .we         (dp_we),
        .addr       (dp_addr),
        .wdata      (dp_wdata),
        .done       (dp_done),
        .rdata      (bus_rdata)
    );

    bus_arbiter i_bus_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_req   (if_req),
        .if_addr  (if_addr),
        .if_done  (if_done),
        .dp_req   (dp_req),
        .dp_we    (dp_we),
        .dp_addr  (dp_addr),
        .dp_wdata (dp_wdata),
        .dp_done  (dp_done),
        .rdata    (bus_rdata),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .prdata   (prdata),
        .pready   (pready)
    );

endmodule

`default_nettype wire

/* dv/apb_mem_model.sv */
`default_nettype none

module apb_mem_model (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire rvf_pkg::word_t paddr,
    input  wire rvf_pkg::word_t pwdata,
    input  wire logic           psel,
    input  wire logic           penable,
    input  wire logic           pwrite,
    input  wire logic [1:0]     wait_count,
    output rvf_pkg::word_t      prdata,
    output logic                pready
);
    timeunit 1ns;
    timeprecision 1ps;

    rvf_pkg::word_t mem [1024];
    logic           written [1024];
    logic [1:0]     wait_left;
    logic [9:0]     index;

    assign index  = paddr[11:2];
    assign pready = psel & penable & (wait_left == 2'd0);

    // Words never written read back as the inverse of the full byte address.
    assign prdata = written[index] ? mem[index] : ~paddr;

    // Wait states for this access are taken in the setup phase.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_left <= 2'd0;
        end else if (psel && !penable) begin
            wait_left <= wait_count;
        end else if (psel && penable && wait_left != 2'd0) begin
            wait_left <= wait_left - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 1024; i++) begin
                written[i] <= 1'b0;
            end
        end else if (pready && pwrite) begin
            written[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pready && pwrite) begin
            mem[index] <= pwdata;
        end
    end

endmodule

`default_nettype wire

/* dv/fetch_subsystem_chk.sv */
`default_nettype none

module fetch_subsystem_chk (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire logic                psel,
    input wire logic                penable,
    input wire logic                pwrite,
    input wire logic                pready,
    input wire rvf_pkg::word_t      paddr,
    input wire rvf_pkg::word_t      pwdata,
    input wire logic                if_done,
    input wire logic                dp_done,
    input wire rvf_pkg::req_owner_e owner
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0; // Failed assertions so far.

    // Access only ever follows a selected cycle.
    penable_with_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel && $past(psel))
    else begin
        fail_count++;
        $error("penable high without psel or without a preceding setup phase");
    end

    // Setup is one cycle and the fields hold into access.
    setup_to_access: assert property (@(posedge clk) disable iff (!rst_n)
        psel && !penable |=> penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else begin
        fail_count++;
        $error("APB setup not followed by a stable access phase");
    end

    access_wait_stable: assert property (@(posedge clk) disable iff (!rst_n)
        penable && !pready |=> penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    else begin
        fail_count++;
        $error("APB fields changed during wait states");
    end

    single_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(if_done && dp_done))
    else begin
        fail_count++;
        $error("if_done and dp_done high together");
    end

    // Instruction fetches never write memory.
    fetch_is_read: assert property (@(posedge clk) disable iff (!rst_n)
        psel && owner == rvf_pkg::owner_fetch |-> !pwrite)
    else begin
        fail_count++;
        $error("fetch transfer issued as a write");
    end

    fetch_done_after_ready: assert property (@(posedge clk) disable iff (!rst_n)
        if_done |-> $past(penable && pready))
    else begin
        fail_count++;
        $error("if_done without a completed access");
    end

    data_done_after_ready: assert property (@(posedge clk) disable iff (!rst_n)
        dp_done |-> $past(penable && pready))
    else begin
        fail_count++;
        $error("dp_done without a completed access");
    end

endmodule

bind bus_arbiter fetch_subsystem_chk i_fetch_subsystem_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pready  (pready),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .if_done (if_done),
    .dp_done (dp_done),
    .owner   (owner)
);

`default_nettype wire

/* dv/tb_fetch_subsystem.sv */
`default_nettype none

module tb_fetch_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [2:0] {op_run, op_hold, op_redirect, op_store, op_load} op_e;

    localparam int num_rows = 14;

    logic           clk;
    logic           rst_n;
    logic           hold;
    logic           redirect_valid;
    rvf_pkg::word_t redirect_pc;
    logic           instr_valid;
    rvf_pkg::word_t instr;
    rvf_pkg::word_t instr_pc;
    logic           dmem_req;
    logic           dmem_we;
    rvf_pkg::word_t dmem_addr;
    rvf_pkg::word_t dmem_wdata;
    logic           dmem_done;
    rvf_pkg::word_t dmem_rdata;
    rvf_pkg::word_t paddr;
    rvf_pkg::word_t pwdata;
    logic           psel;
    logic           penable;
    logic           pwrite;
    rvf_pkg::word_t prdata;
    logic           pready;
    logic [1:0]     wait_count = 2'd0;

    op_e            row_op    [num_rows];
    int             row_count [num_rows];
    rvf_pkg::word_t row_addr  [num_rows];
    rvf_pkg::word_t row_data  [num_rows];

    logic [31:0]    lcg_state   = 32'h20e;
    int             errors      = 0;
    int             chk_fails   = 0;
    int             valid_count = 0;
    int             hold_valids = 0;
    int             timeout_limit;
    rvf_pkg::word_t exp_pc      = 32'h8000_0000; // First fetch after reset.
    rvf_pkg::word_t jump_target = '0;
    logic           jump_armed  = 1'b0;
    int             stale_left  = 0;

    fetch_subsystem i_fetch_subsystem (
        .clk            (clk),
        .rst_n          (rst_n),
        .hold           (hold),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_pc       (instr_pc),
        .dmem_req       (dmem_req),
        .dmem_we        (dmem_we),
        .dmem_addr      (dmem_addr),
        .dmem_wdata     (dmem_wdata),
        .dmem_done      (dmem_done),
        .dmem_rdata     (dmem_rdata),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .prdata         (prdata),
        .pready         (pready)
    );

    apb_mem_model i_apb_mem_model (
        .clk        (clk),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .wait_count (wait_count),
        .prdata     (prdata),
        .pready     (pready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [1:0] next_wait();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:30]; // Upper bits have the longest period.
    endfunction

    always @(negedge clk) begin
        wait_count <= next_wait();
    end

    task automatic check_value(input string name, input rvf_pkg::word_t actual,
                               input rvf_pkg::word_t expected);
        assert (actual === expected) else begin
            errors++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_low(input string name, input logic actual);
        assert (actual === 1'b0) else begin
            errors++;
            $display("Fail at %0t: %s = %b, expected 0", $time, name, actual);
        end
    endtask

    // Accepts the target, or one word of the old sequence right after a redirect.
    task automatic check_instr();
        if (jump_armed && instr_pc === jump_target) begin
            jump_armed = 1'b0;
            exp_pc     = jump_target;
        end else if (jump_armed) begin
            assert (stale_left > 0) else begin
                errors++;
                $display("More than one old instruction after a redirect at %0t", $time);
            end
            stale_left--;
        end
        check_value("instr_pc", instr_pc, exp_pc);
        check_value("instr", instr, ~exp_pc);
        exp_pc = exp_pc + 32'd4;
        valid_count++;
    endtask

    always @(posedge clk) begin
        if (rst_n && instr_valid) begin
            check_instr();
        end
        if (rst_n && redirect_valid) begin
            jump_target = redirect_pc;
            jump_armed  = 1'b1;
            stale_left  = 1;
        end
        if (hold && instr_valid) begin
            hold_valids++;
        end
    end

    function automatic void set_row(input int i, input op_e op, input int n,
                                    input rvf_pkg::word_t a, input rvf_pkg::word_t d);
        row_op[i]    = op;
        row_count[i] = n;
        row_addr[i]  = a;
        row_data[i]  = d;
    endfunction

    task automatic fill_table();
        set_row(0,  op_run,      8,  '0,            '0);
        set_row(1,  op_hold,     20, '0,            '0);
        set_row(2,  op_run,      6,  '0,            '0);
        set_row(3,  op_redirect, 1,  32'h8000_0400, '0);
        set_row(4,  op_run,      8,  '0,            '0);
        set_row(5,  op_store,    1,  32'h0000_0840, 32'h1234_5678);
        set_row(6,  op_load,     1,  32'h0000_0840, 32'h1234_5678);
        set_row(7,  op_load,     1,  32'h0000_0c00, 32'hffff_f3ff); // Untouched word.
        set_row(8,  op_run,      6,  '0,            '0);
        set_row(9,  op_store,    1,  32'h0000_0a04, 32'hcafe_f00d);
        set_row(10, op_load,     1,  32'h0000_0a04, 32'hcafe_f00d);
        set_row(11, op_redirect, 1,  32'h8000_0100, '0);
        set_row(12, op_hold,     3,  '0,            '0);
        set_row(13, op_run,      10, '0,            '0);
    endtask

    task automatic run_instrs(input int n);
        int target;
        target = valid_count + n;
        while (valid_count < target) begin
            @(negedge clk);
        end
    endtask

    task automatic hold_for(input int n);
        int seen_before;
        seen_before = hold_valids;
        hold = 1'b1;
        repeat (n) @(negedge clk);
        hold = 1'b0;
        assert (hold_valids - seen_before <= 1) else begin
            errors++;
            $display("More than one instruction arrived while hold was high at %0t", $time);
        end
    endtask

    task automatic pulse_redirect(input rvf_pkg::word_t target);
        redirect_pc    = target;
        redirect_valid = 1'b1;
        @(negedge clk);
        redirect_valid = 1'b0;
    endtask

    task automatic data_access(input logic is_store, input rvf_pkg::word_t addr,
                               input rvf_pkg::word_t data);
        dmem_req   = 1'b1;
        dmem_we    = is_store;
        dmem_addr  = addr;
        dmem_wdata = is_store ? data : '0;
        @(negedge clk);
        dmem_req = 1'b0;
        while (!dmem_done) begin
            @(negedge clk);
        end
        if (!is_store) begin
            check_value("dmem_rdata", dmem_rdata, data);
        end
        @(negedge clk);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (cycles < timeout_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        hold           = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        dmem_req       = 1'b0;
        dmem_we        = 1'b0;
        dmem_addr      = '0;
        dmem_wdata     = '0;
        fill_table();
        timeout_limit = 100;
        for (int i = 0; i < num_rows; i++) begin
            timeout_limit += row_count[i] * 20;
        end
        repeat (2) @(negedge clk);
        check_low("psel", psel);
        check_low("penable", penable);
        check_low("instr_valid", instr_valid);
        check_low("dmem_done", dmem_done);
        rst_n = 1'b1;
        for (int i = 0; i < num_rows; i++) begin
            case (row_op[i])
                op_run:      run_instrs(row_count[i]);
                op_hold:     hold_for(row_count[i]);
                op_redirect: pulse_redirect(row_addr[i]);
                op_store:    data_access(1'b1, row_addr[i], row_data[i]);
                op_load:     data_access(1'b0, row_addr[i], row_data[i]);
                default:     ;
            endcase
        end
        repeat (4) @(negedge clk);
        chk_fails = i_fetch_subsystem.i_bus_arbiter.i_fetch_subsystem_chk.fail_count;
        $display("Errors: %0d checks, %0d assertions; %0d instructions seen",
                 errors, chk_fails, valid_count);
        if (errors == 0 && chk_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_subsystem.f */
rtl/rvf_pkg.sv
rtl/pc_gen.sv
rtl/instr_fetch.sv
rtl/data_port.sv
rtl/bus_arbiter.sv
rtl/fetch_subsystem.sv
dv/apb_mem_model.sv
dv/fetch_subsystem_chk.sv
dv/tb_fetch_subsystem.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch_subsystem -Mdir obj_dir -f fetch_subsystem.f

./obj_dir/Vtb_fetch_subsystem +verilator+error+limit+1000 | tee sim.log

if grep -qF '** FAIL **' sim.log; then
    exit 1
fi
grep -qF '** PASS **' sim.log
